//--- design/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_XLEN   32
`define CSR_ADDR_W 12

// Machine trap setup and handling
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344

// Machine counters and their user aliases
`define CSR_MCYCLE    12'hB00
`define CSR_MINSTRET  12'hB02
`define CSR_MCYCLEH   12'hB80
`define CSR_MINSTRETH 12'hB82
`define CSR_CYCLE     12'hC00
`define CSR_TIME      12'hC01
`define CSR_INSTRET   12'hC02
`define CSR_CYCLEH    12'hC80
`define CSR_TIMEH     12'hC81
`define CSR_INSTRETH  12'hC82

// Writable bits per register
`define CSR_MASK_MSTATUS 32'h007E19AA
`define CSR_MASK_MISA    32'h00301000
`define CSR_MASK_MIE     32'h00000888
`define CSR_MASK_ALIGN   32'hFFFFFFFC
`define CSR_MASK_FULL    32'hFFFFFFFF

`define CSR_MISA_VALUE   32'h40101100  // MXL=1, U, M, I

// Interrupt bits in mip and mie
`define CSR_IRQ_MSI 3
`define CSR_IRQ_MTI 7
`define CSR_IRQ_MEI 11

`endif

//--- design/csr_pkg.sv
package csr_pkg;

    typedef enum logic [1:0] {
        WRITE = 2'b01,
        SET   = 2'b10,
        CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 5'd0,
        INSTRUCTION_ACCESS_FAULT       = 5'd1,
        ILLEGAL_INSTRUCTION            = 5'd2,
        BREAKPOINT                     = 5'd3,
        LOAD_ADDRESS_MISALIGNED        = 5'd4,
        LOAD_ACCESS_FAULT              = 5'd5,
        STORE_ADDRESS_MISALIGNED       = 5'd6,
        STORE_ACCESS_FAULT             = 5'd7,
        ECALL_U                        = 5'd8,
        ECALL_M                        = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    // Strobe positions, one per writable register
    localparam int unsigned WSEL_MSTATUS   = 0;
    localparam int unsigned WSEL_MISA      = 1;
    localparam int unsigned WSEL_MIE       = 2;
    localparam int unsigned WSEL_MTVEC     = 3;
    localparam int unsigned WSEL_MSCRATCH  = 4;
    localparam int unsigned WSEL_MEPC      = 5;
    localparam int unsigned WSEL_MCAUSE    = 6;
    localparam int unsigned WSEL_MTVAL     = 7;
    localparam int unsigned WSEL_MCYCLE    = 8;
    localparam int unsigned WSEL_MCYCLEH   = 9;
    localparam int unsigned WSEL_MINSTRET  = 10;
    localparam int unsigned WSEL_MINSTRETH = 11;
    localparam int unsigned WSEL_W         = 12;

    typedef logic [WSEL_W-1:0] csr_wsel_t;

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic       sd;
            logic [7:0] wpri_hi;
            logic       tsr;
            logic       tw;
            logic       tvm;
            logic       mxr;
            logic       sum;
            logic       mprv;
            logic [1:0] xs;
            logic [1:0] fs;
            logic [1:0] mpp;
            logic [1:0] vs;
            logic       spp;
            logic       mpie;
            logic       ube;
            logic       spie;
            logic       wpri4;
            logic       mie;
            logic       wpri2;
            logic       sie;
            logic       wpri0;
        } fields;
    } mstatus_u;

endpackage

//--- design/csr_access.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_access (
    input  logic [`CSR_ADDR_W-1:0] addr_i,
    input  csr_pkg::csr_op_e       op_i,
    input  logic [`CSR_XLEN-1:0]   wdata_i,
    input  logic                   read_en_i,
    input  logic                   write_en_i,
    input  logic                   killed_i,
    input  logic [`CSR_XLEN-1:0]   mstatus_i,
    input  logic [`CSR_XLEN-1:0]   misa_i,
    input  logic [`CSR_XLEN-1:0]   mie_i,
    input  logic [`CSR_XLEN-1:0]   mip_i,
    input  logic [`CSR_XLEN-1:0]   mtvec_i,
    input  logic [`CSR_XLEN-1:0]   mscratch_i,
    input  logic [`CSR_XLEN-1:0]   mepc_i,
    input  logic [`CSR_XLEN-1:0]   mcause_i,
    input  logic [`CSR_XLEN-1:0]   mtval_i,
    input  logic [63:0]            mcycle_i,
    input  logic [63:0]            minstret_i,
    input  logic [63:0]            mtime_i,
    output logic [`CSR_XLEN-1:0]   wr_data_o,
    output csr_pkg::csr_wsel_t     wsel_o,
    output logic [`CSR_XLEN-1:0]   rdata_o
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0] cur_val;
    logic [`CSR_XLEN-1:0] wmask;
    logic [`CSR_XLEN-1:0] masked_data;
    csr_wsel_t            wsel_dec;
    logic                 read_allowed;
    logic                 write_allowed;

    assign read_allowed  = read_en_i && !killed_i;
    assign write_allowed = write_en_i && !killed_i;

    //////////////////////////////////////////////////
    // Current value, also the read data
    //////////////////////////////////////////////////
    always_comb begin
        case (addr_i)
            `CSR_MSTATUS:   cur_val = mstatus_i;
            `CSR_MISA:      cur_val = misa_i;
            `CSR_MIE:       cur_val = mie_i;
            `CSR_MIP:       cur_val = mip_i;
            `CSR_MTVEC:     cur_val = mtvec_i;
            `CSR_MSCRATCH:  cur_val = mscratch_i;
            `CSR_MEPC:      cur_val = mepc_i;
            `CSR_MCAUSE:    cur_val = mcause_i;
            `CSR_MTVAL:     cur_val = mtval_i;
            `CSR_MCYCLE,
            `CSR_CYCLE:     cur_val = mcycle_i[31:0];
            `CSR_MCYCLEH,
            `CSR_CYCLEH:    cur_val = mcycle_i[63:32];
            `CSR_MINSTRET,
            `CSR_INSTRET:   cur_val = minstret_i[31:0];
            `CSR_MINSTRETH,
            `CSR_INSTRETH:  cur_val = minstret_i[63:32];
            `CSR_TIME:      cur_val = mtime_i[31:0];
            `CSR_TIMEH:     cur_val = mtime_i[63:32];
            default:        cur_val = '0;  // ID registers land here
        endcase
    end

    // Writable bits, zero for read-only addresses
    always_comb begin
        case (addr_i)
            `CSR_MSTATUS:   wmask = `CSR_MASK_MSTATUS;
            `CSR_MISA:      wmask = `CSR_MASK_MISA;
            `CSR_MIE:       wmask = `CSR_MASK_MIE;
            `CSR_MTVEC,
            `CSR_MEPC:      wmask = `CSR_MASK_ALIGN;
            `CSR_MSCRATCH, `CSR_MCAUSE, `CSR_MTVAL,
            `CSR_MCYCLE, `CSR_MCYCLEH,
            `CSR_MINSTRET, `CSR_MINSTRETH:
                            wmask = `CSR_MASK_FULL;
            default:        wmask = '0;
        endcase
    end

    always_comb begin
        wsel_dec = '0;
        case (addr_i)
            `CSR_MSTATUS:   wsel_dec[WSEL_MSTATUS]   = 1'b1;
            `CSR_MISA:      wsel_dec[WSEL_MISA]      = 1'b1;
            `CSR_MIE:       wsel_dec[WSEL_MIE]       = 1'b1;
            `CSR_MTVEC:     wsel_dec[WSEL_MTVEC]     = 1'b1;
            `CSR_MSCRATCH:  wsel_dec[WSEL_MSCRATCH]  = 1'b1;
            `CSR_MEPC:      wsel_dec[WSEL_MEPC]      = 1'b1;
            `CSR_MCAUSE:    wsel_dec[WSEL_MCAUSE]    = 1'b1;
            `CSR_MTVAL:     wsel_dec[WSEL_MTVAL]     = 1'b1;
            `CSR_MCYCLE:    wsel_dec[WSEL_MCYCLE]    = 1'b1;
            `CSR_MCYCLEH:   wsel_dec[WSEL_MCYCLEH]   = 1'b1;
            `CSR_MINSTRET:  wsel_dec[WSEL_MINSTRET]  = 1'b1;
            `CSR_MINSTRETH: wsel_dec[WSEL_MINSTRETH] = 1'b1;
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // Operation
    //////////////////////////////////////////////////
    assign masked_data = wdata_i & wmask;

    always_comb begin
        case (op_i)
            WRITE:   wr_data_o = (cur_val & ~wmask) | masked_data;
            SET:     wr_data_o = cur_val | masked_data;
            CLEAR:   wr_data_o = cur_val & ~masked_data;
            default: wr_data_o = cur_val;
        endcase
    end

    assign wsel_o  = write_allowed ? wsel_dec : '0;
    assign rdata_o = read_allowed ? cur_val : '0;

endmodule

//--- design/csr_trap_regs.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_trap_regs (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [`CSR_XLEN-1:0] wr_data_i,
    input  csr_pkg::csr_wsel_t   wsel_i,
    input  logic                 raise_exception_i,
    input  csr_pkg::exc_code_e   exception_code_i,
    input  logic [`CSR_XLEN-1:0] pc_i,
    input  logic [`CSR_XLEN-1:0] instruction_i,
    input  logic                 machine_return_i,
    input  logic                 irq_ack_i,
    input  logic                 jump_i,
    input  logic [`CSR_XLEN-1:0] jump_target_i,
    input  logic [`CSR_XLEN-1:0] irq_i,
    output logic [`CSR_XLEN-1:0] mstatus_o,
    output logic [`CSR_XLEN-1:0] misa_o,
    output logic [`CSR_XLEN-1:0] mie_o,
    output logic [`CSR_XLEN-1:0] mip_o,
    output logic [`CSR_XLEN-1:0] mtvec_o,
    output logic [`CSR_XLEN-1:0] mscratch_o,
    output logic [`CSR_XLEN-1:0] mepc_o,
    output logic [`CSR_XLEN-1:0] mcause_o,
    output logic [`CSR_XLEN-1:0] mtval_o,
    output csr_pkg::priv_e       privilege_o,
    output logic                 irq_pending_o
);
    import csr_pkg::*;

    // Stored mstatus fields
    logic       st_mie;
    logic       st_mpie;
    logic [1:0] st_mpp;
    logic       st_sum;
    logic       st_tvm;
    logic       st_tw;
    logic       st_tsr;
    mstatus_u   status_rd;
    mstatus_u   status_wr;

    logic [`CSR_XLEN-1:0] irq_active;
    logic                 irq_take;
    irq_code_e            irq_code;
    irq_code_e            irq_code_nxt;

    always_comb begin
        status_rd             = '0;
        status_rd.fields.mie  = st_mie;
        status_rd.fields.mpie = st_mpie;
        status_rd.fields.mpp  = st_mpp;
        status_rd.fields.sum  = st_sum;
        status_rd.fields.tvm  = st_tvm;
        status_rd.fields.tw   = st_tw;
        status_rd.fields.tsr  = st_tsr;
    end

    assign status_wr.raw = wr_data_i;
    assign mstatus_o     = status_rd.raw;

    //////////////////////////////////////////////////
    // Trap events and CSR writes
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            st_mie      <= 1'b0;
            st_mpie     <= 1'b0;
            st_mpp      <= 2'b00;
            st_sum      <= 1'b0;
            st_tvm      <= 1'b0;
            st_tw       <= 1'b0;
            st_tsr      <= 1'b0;
            misa_o      <= `CSR_MISA_VALUE;
            mie_o       <= '0;
            mtvec_o     <= '0;
            mscratch_o  <= '0;
            mepc_o      <= '0;
            mcause_o    <= '0;
            mtval_o     <= '0;
            privilege_o <= MACHINE;
        end else if (machine_return_i) begin
            st_mie      <= st_mpie;
            privilege_o <= priv_e'(st_mpp);
        end else if (raise_exception_i || irq_ack_i) begin
            st_mpp      <= privilege_o;  // Trap entry, common part
            st_mpie     <= st_mie;
            st_mie      <= 1'b0;
            privilege_o <= MACHINE;
            if (raise_exception_i) begin
                mepc_o   <= pc_i;
                mcause_o <= {1'b0, 26'd0, exception_code_i};
                mtval_o  <= (exception_code_i == ILLEGAL_INSTRUCTION) ? instruction_i : pc_i;
            end else begin
                mcause_o <= {1'b1, 26'd0, irq_code};
                // Current instruction retires, so return to the next one
                mepc_o   <= jump_i ? jump_target_i : pc_i + 32'd4;
            end
        end else begin
            if (wsel_i[WSEL_MSTATUS]) begin
                st_mie  <= status_wr.fields.mie;
                st_mpie <= status_wr.fields.mpie;
                st_mpp  <= status_wr.fields.mpp;
                st_sum  <= status_wr.fields.sum;
                st_tvm  <= status_wr.fields.tvm;
                st_tw   <= status_wr.fields.tw;
                st_tsr  <= status_wr.fields.tsr;
            end
            if (wsel_i[WSEL_MISA])     misa_o     <= wr_data_i;
            if (wsel_i[WSEL_MIE])      mie_o      <= wr_data_i;
            if (wsel_i[WSEL_MTVEC])    mtvec_o    <= wr_data_i;
            if (wsel_i[WSEL_MSCRATCH]) mscratch_o <= wr_data_i;
            if (wsel_i[WSEL_MEPC])     mepc_o     <= wr_data_i;
            if (wsel_i[WSEL_MCAUSE])   mcause_o   <= wr_data_i;
            if (wsel_i[WSEL_MTVAL])    mtval_o    <= wr_data_i;
        end
    end

    //////////////////////////////////////////////////
    // Interrupt detection
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_o <= '0;
        end else begin
            mip_o <= irq_i;  // Sampled every edge
        end
    end

    assign irq_active = mie_o & mip_o;
    assign irq_take   = st_mie && (irq_active != '0) && !irq_ack_i;

    // External first, then software, then timer
    always_comb begin
        if (irq_active[`CSR_IRQ_MEI]) begin
            irq_code_nxt = M_EXT_INT;
        end else if (irq_active[`CSR_IRQ_MSI]) begin
            irq_code_nxt = M_SW_INT;
        end else begin
            irq_code_nxt = M_TIM_INT;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            irq_pending_o <= 1'b0;
        end else begin
            irq_pending_o <= irq_take;
        end
    end

    // Held for mcause on the acknowledge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            irq_code <= M_TIM_INT;
        end else if (irq_take) begin
            irq_code <= irq_code_nxt;
        end
    end

endmodule

//--- design/csr_counters.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_counters (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 killed_i,
    input  logic [`CSR_XLEN-1:0] wr_data_i,
    input  csr_pkg::csr_wsel_t   wsel_i,
    output logic [63:0]          mcycle_o,
    output logic [63:0]          minstret_o
);
    import csr_pkg::*;

    // Increment, then overwrite whichever half is written
    function automatic logic [63:0] count_next(
        input logic [63:0]          count,
        input logic                 step,
        input logic                 wr_lo,
        input logic                 wr_hi,
        input logic [`CSR_XLEN-1:0] data
    );
        logic [63:0] nxt;
        nxt = count + {63'd0, step};
        if (wr_lo) begin
            nxt[31:0] = data;
        end
        if (wr_hi) begin
            nxt[63:32] = data;
        end
        return nxt;
    endfunction

    //////////////////////////////////////////////////
    // mcycle and minstret
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= count_next(mcycle_o, 1'b1,
                                     wsel_i[WSEL_MCYCLE], wsel_i[WSEL_MCYCLEH], wr_data_i);
            minstret_o <= count_next(minstret_o, !killed_i,  // Retired only
                                     wsel_i[WSEL_MINSTRET], wsel_i[WSEL_MINSTRETH], wr_data_i);
        end
    end

endmodule

//--- design/csr_bank.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_bank (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   read_en_i,
    input  logic                   write_en_i,
    input  logic                   killed_i,
    input  csr_pkg::csr_op_e       op_i,
    input  logic [`CSR_ADDR_W-1:0] addr_i,
    input  logic [`CSR_XLEN-1:0]   wdata_i,
    output logic [`CSR_XLEN-1:0]   rdata_o,
    input  logic                   raise_exception_i,
    input  csr_pkg::exc_code_e     exception_code_i,
    input  logic [`CSR_XLEN-1:0]   pc_i,
    input  logic [`CSR_XLEN-1:0]   instruction_i,
    input  logic                   machine_return_i,
    input  logic                   jump_i,
    input  logic [`CSR_XLEN-1:0]   jump_target_i,
    input  logic [63:0]            mtime_i,
    input  logic [`CSR_XLEN-1:0]   irq_i,
    input  logic                   irq_ack_i,
    output logic                   irq_pending_o,
    output csr_pkg::priv_e         privilege_o,
    output logic [`CSR_XLEN-1:0]   mepc_o,
    output logic [`CSR_XLEN-1:0]   mtvec_o
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0] wr_data;
    csr_wsel_t            wsel;
    logic [`CSR_XLEN-1:0] mstatus, misa, mie, mip, mscratch, mcause, mtval;
    logic [63:0]          mcycle, minstret;

    csr_access csr_access_inst (
        .addr_i      (addr_i),
        .op_i        (op_i),
        .wdata_i     (wdata_i),
        .read_en_i   (read_en_i),
        .write_en_i  (write_en_i),
        .killed_i    (killed_i),
        .mstatus_i   (mstatus),
        .misa_i      (misa),
        .mie_i       (mie),
        .mip_i       (mip),
        .mtvec_i     (mtvec_o),
        .mscratch_i  (mscratch),
        .mepc_i      (mepc_o),
        .mcause_i    (mcause),
        .mtval_i     (mtval),
        .mcycle_i    (mcycle),
        .minstret_i  (minstret),
        .mtime_i     (mtime_i),
        .wr_data_o   (wr_data),
        .wsel_o      (wsel),
        .rdata_o     (rdata_o)
    );

    csr_trap_regs csr_trap_regs_inst (
        .clk               (clk),
        .reset_n           (reset_n),
        .wr_data_i         (wr_data),
        .wsel_i            (wsel),
        .raise_exception_i (raise_exception_i),
        .exception_code_i  (exception_code_i),
        .pc_i              (pc_i),
        .instruction_i     (instruction_i),
        .machine_return_i  (machine_return_i),
        .irq_ack_i         (irq_ack_i),
        .jump_i            (jump_i),
        .jump_target_i     (jump_target_i),
        .irq_i             (irq_i),
        .mstatus_o         (mstatus),
        .misa_o            (misa),
        .mie_o             (mie),
        .mip_o             (mip),
        .mtvec_o           (mtvec_o),
        .mscratch_o        (mscratch),
        .mepc_o            (mepc_o),
        .mcause_o          (mcause),
        .mtval_o           (mtval),
        .privilege_o       (privilege_o),
        .irq_pending_o     (irq_pending_o)
    );

    csr_counters csr_counters_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .killed_i   (killed_i),
        .wr_data_i  (wr_data),
        .wsel_i     (wsel),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

endmodule

//--- test/tb_csr_bank.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module tb_csr_bank;
    import csr_pkg::*;

    localparam int CYCLE_LIMIT = 400;  // Roughly three times the full sequence
    // Bits that mstatus keeps: MIE, MPIE, MPP, SUM, TVM, TW, TSR
    localparam logic [31:0] STORED_MSTATUS = (32'd1 << 3) | (32'd1 << 7) | (32'd3 << 11)
                                           | (32'd1 << 18) | (32'd1 << 20) | (32'd1 << 21)
                                           | (32'd1 << 22);

    logic        clk;
    logic        reset_n;
    logic        read_en_i;
    logic        write_en_i;
    logic        killed_i;
    csr_op_e     op_i;
    logic [11:0] addr_i;
    logic [31:0] wdata_i;
    logic [31:0] rdata_o;
    logic        raise_exception_i;
    exc_code_e   exception_code_i;
    logic [31:0] pc_i;
    logic [31:0] instruction_i;
    logic        machine_return_i;
    logic        jump_i;
    logic [31:0] jump_target_i;
    logic [63:0] mtime_i;
    logic [31:0] irq_i;
    logic        irq_ack_i;
    logic        irq_pending_o;
    priv_e       privilege_o;
    logic [31:0] mepc_o;
    logic [31:0] mtvec_o;

    integer      seed;
    int          cycle_count = 0;
    logic [31:0] scratch_exp = '0;  // Expected register contents
    logic [31:0] mtvec_exp   = '0;
    logic [31:0] mie_exp     = '0;

    csr_bank csr_bank_inst (
        .clk (clk), .reset_n (reset_n),
        .read_en_i (read_en_i), .write_en_i (write_en_i), .killed_i (killed_i),
        .op_i (op_i), .addr_i (addr_i), .wdata_i (wdata_i), .rdata_o (rdata_o),
        .raise_exception_i (raise_exception_i), .exception_code_i (exception_code_i),
        .pc_i (pc_i), .instruction_i (instruction_i), .machine_return_i (machine_return_i),
        .jump_i (jump_i), .jump_target_i (jump_target_i), .mtime_i (mtime_i),
        .irq_i (irq_i), .irq_ack_i (irq_ack_i), .irq_pending_o (irq_pending_o),
        .privilege_o (privilege_o), .mepc_o (mepc_o), .mtvec_o (mtvec_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
            $display("Regression failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    //////////////////////////////////////////////////
    // Checking and reference model
    //////////////////////////////////////////////////
    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Only bits under the mask may change
    function automatic logic [31:0] apply_op(input logic [31:0] old, input csr_op_e op,
                                             input logic [31:0] data, input logic [31:0] mask);
        logic [31:0] writable;
        writable = data & mask;
        case (op)
            WRITE:   return (old & ~mask) | writable;
            SET:     return old | writable;
            default: return old & ~writable;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Bus and event drivers
    //////////////////////////////////////////////////
    task automatic write_csr(input logic [11:0] addr, input csr_op_e op,
                             input logic [31:0] data, input logic kill);
        @(posedge clk);
        addr_i     <= addr;
        op_i       <= op;
        wdata_i    <= data;
        killed_i   <= kill;
        read_en_i  <= 1'b0;
        write_en_i <= 1'b1;
        @(posedge clk);  // Write lands on this edge
        write_en_i <= 1'b0;
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic kill, output logic [31:0] data);
        @(posedge clk);
        addr_i     <= addr;
        killed_i   <= kill;
        write_en_i <= 1'b0;
        read_en_i  <= 1'b1;
        @(negedge clk);
        data = rdata_o;
    endtask

    task automatic update_and_compare(input logic [11:0] addr, input csr_op_e op,
                                      input logic [31:0] data, input logic [31:0] mask,
                                      inout logic [31:0] model);
        logic [31:0] rd;
        model = apply_op(model, op, data, mask);
        write_csr(addr, op, data, 1'b0);
        read_csr(addr, 1'b0, rd);
        check_equal(rd, model, $sformatf("csr %h read-back after op %s", addr, op.name()));
    endtask

    task automatic raise_exception(input exc_code_e code, input logic [31:0] pc,
                                   input logic [31:0] instr);
        @(posedge clk);
        raise_exception_i <= 1'b1;
        exception_code_i  <= code;
        pc_i              <= pc;
        instruction_i     <= instr;
        @(posedge clk);
        raise_exception_i <= 1'b0;
    endtask

    task automatic return_from_trap();
        @(posedge clk);
        machine_return_i <= 1'b1;
        @(posedge clk);
        machine_return_i <= 1'b0;
    endtask

    task automatic acknowledge_irq(input logic [31:0] pc, input logic jump,
                                   input logic [31:0] target);
        @(posedge clk);
        irq_ack_i     <= 1'b1;
        pc_i          <= pc;
        jump_i        <= jump;
        jump_target_i <= target;
        @(posedge clk);
        irq_ack_i     <= 1'b0;
        jump_i        <= 1'b0;
    endtask

    task automatic wait_pending(input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (irq_pending_o !== 1'b1 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (irq_pending_o !== 1'b1) begin
            $display("Interrupt pending flag did not rise within %0d cycles", limit);
            $display("Regression failed");
            $fatal(1, "Interrupt never became pending");
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic test_masked_ops();
        logic [31:0] rd;
        logic [31:0] val [0:6];
        foreach (val[i]) val[i] = $random(seed);
        read_csr(`CSR_MISA, 1'b0, rd);
        check_equal(rd, `CSR_MISA_VALUE, "misa after reset");
        update_and_compare(`CSR_MSCRATCH, WRITE, val[0], `CSR_MASK_FULL, scratch_exp);
        update_and_compare(`CSR_MTVEC, WRITE, val[1], `CSR_MASK_ALIGN, mtvec_exp);
        update_and_compare(`CSR_MIE, WRITE, val[2], `CSR_MASK_MIE, mie_exp);
        update_and_compare(`CSR_MSCRATCH, SET, val[3], `CSR_MASK_FULL, scratch_exp);
        update_and_compare(`CSR_MSCRATCH, CLEAR, val[4], `CSR_MASK_FULL, scratch_exp);
        update_and_compare(`CSR_MTVEC, SET, val[5], `CSR_MASK_ALIGN, mtvec_exp);
        update_and_compare(`CSR_MTVEC, CLEAR, val[6], `CSR_MASK_ALIGN, mtvec_exp);
        update_and_compare(`CSR_MIE, SET, 32'hFFFF_FFFF, `CSR_MASK_MIE, mie_exp);
        update_and_compare(`CSR_MIE, CLEAR, 32'h0000_0008, `CSR_MASK_MIE, mie_exp);
        check_equal(mtvec_o, mtvec_exp, "mtvec output port");
        write_csr(`CSR_MSTATUS, WRITE, 32'hFFFF_FFFF, 1'b0);
        read_csr(`CSR_MSTATUS, 1'b0, rd);
        check_equal(rd, STORED_MSTATUS, "mstatus after writing all ones");
        write_csr(`CSR_MSTATUS, WRITE, 32'h0, 1'b0);
    endtask

    task automatic test_killed_access();
        logic [31:0] rd;
        read_csr(`CSR_MSCRATCH, 1'b1, rd);
        check_equal(rd, 32'h0, "killed read of mscratch");
        write_csr(`CSR_MSCRATCH, WRITE, ~scratch_exp, 1'b1);
        read_csr(`CSR_MSCRATCH, 1'b0, rd);
        check_equal(rd, scratch_exp, "mscratch after killed write");
    endtask

    task automatic test_exception_return();
        logic [31:0] rd;
        logic [31:0] instr;
        logic        saved_mpie;
        instr      = $random(seed);
        saved_mpie = 1'b1;  // MIE just before the trap
        write_csr(`CSR_MSTATUS, WRITE, 32'h0000_0080, 1'b0);  // MPIE set, MPP user
        return_from_trap();
        @(negedge clk);
        check_equal(privilege_o, USER, "privilege after first return");
        write_csr(`CSR_MSTATUS, WRITE, 32'h0000_1808, 1'b0);  // MIE set, MPIE clear, MPP machine
        raise_exception(ILLEGAL_INSTRUCTION, 32'h0000_1040, instr);
        @(negedge clk);
        check_equal(privilege_o, MACHINE, "privilege after exception");
        read_csr(`CSR_MEPC, 1'b0, rd);
        check_equal(rd, 32'h0000_1040, "mepc after exception");
        read_csr(`CSR_MCAUSE, 1'b0, rd);
        check_equal(rd, 32'd2, "mcause after illegal instruction");
        read_csr(`CSR_MTVAL, 1'b0, rd);
        check_equal(rd, instr, "mtval holds the instruction");
        read_csr(`CSR_MSTATUS, 1'b0, rd);
        check_equal(rd[3], 1'b0, "mstatus.MIE cleared on trap");
        check_equal(rd[12:11], USER, "mstatus.MPP holds user mode");
        check_equal(rd[7], saved_mpie, "mstatus.MPIE holds the old MIE");
        return_from_trap();
        @(negedge clk);
        check_equal(privilege_o, USER, "privilege after machine return");
        read_csr(`CSR_MSTATUS, 1'b0, rd);
        check_equal(rd[3], saved_mpie, "mstatus.MIE restored from MPIE");
        raise_exception(BREAKPOINT, 32'h0000_2208, instr);
        read_csr(`CSR_MTVAL, 1'b0, rd);
        check_equal(rd, 32'h0000_2208, "mtval holds pc for a breakpoint");
    endtask

    task automatic test_interrupts();
        logic [31:0] rd;
        write_csr(`CSR_MIE, WRITE, 32'd1 << `CSR_IRQ_MTI, 1'b0);
        write_csr(`CSR_MSTATUS, WRITE, 32'h0000_0008, 1'b0);
        @(posedge clk);
        irq_i <= 32'd1 << `CSR_IRQ_MTI;
        @(posedge clk);  // mip samples the line
        @(negedge clk);
        check_equal(irq_pending_o, 1'b0, "pending one edge after irq");
        @(posedge clk);
        @(negedge clk);
        check_equal(irq_pending_o, 1'b1, "pending two edges after irq");
        read_csr(`CSR_MIP, 1'b0, rd);
        check_equal(rd, 32'd1 << `CSR_IRQ_MTI, "mip shows the timer line");
        acknowledge_irq(32'h0000_4000, 1'b0, 32'h0);
        @(negedge clk);
        check_equal(irq_pending_o, 1'b0, "pending after acknowledge");
        read_csr(`CSR_MCAUSE, 1'b0, rd);
        check_equal(rd, 32'h8000_0007, "mcause for the timer interrupt");
        check_equal(mepc_o, 32'h0000_4004, "mepc is pc plus 4");
        write_csr(`CSR_MSTATUS, WRITE, 32'h0000_0008, 1'b0);
        wait_pending(8);
        acknowledge_irq(32'h0000_5000, 1'b1, 32'h0000_5F00);
        read_csr(`CSR_MEPC, 1'b0, rd);
        check_equal(rd, 32'h0000_5F00, "mepc takes the jump target");
        @(posedge clk);
        irq_i <= '0;
        write_csr(`CSR_MIE, WRITE, 32'h0, 1'b0);
    endtask

    task automatic test_counters();
        logic [31:0] val;
        logic [31:0] inst0;
        logic [63:0] tm;
        val = $random(seed) & 32'h7FFF_FFFF;  // No carry into the high half
        tm  = {$random(seed), $random(seed)};
        @(posedge clk);
        addr_i     <= `CSR_MCYCLE;
        op_i       <= WRITE;
        wdata_i    <= val;
        killed_i   <= 1'b0;
        write_en_i <= 1'b1;
        @(posedge clk);
        write_en_i <= 1'b0;
        read_en_i  <= 1'b1;
        @(negedge clk);
        check_equal(rdata_o, val, "mcycle in the cycle after the write");
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_equal(rdata_o, val + 32'd5, "mcycle five cycles later");
        write_csr(`CSR_MCYCLEH, WRITE, 32'h0000_00A5, 1'b0);
        addr_i    <= `CSR_CYCLEH;
        read_en_i <= 1'b1;
        @(negedge clk);
        check_equal(rdata_o, 32'h0000_00A5, "cycleh after a high-half write");
        @(posedge clk);
        addr_i <= `CSR_INSTRET;
        @(negedge clk);
        inst0 = rdata_o;
        @(posedge clk);
        killed_i <= 1'b1;
        repeat (4) @(posedge clk);
        killed_i <= 1'b0;
        @(negedge clk);
        check_equal(rdata_o, inst0 + 32'd1, "instret frozen while killed");
        @(posedge clk);
        mtime_i <= tm;
        @(negedge clk);
        check_equal(rdata_o, inst0 + 32'd2, "instret counts again");
        read_csr(`CSR_TIME, 1'b0, val);
        check_equal(val, tm[31:0], "time mirrors mtime low");
        read_csr(`CSR_TIMEH, 1'b0, val);
        check_equal(val, tm[63:32], "timeh mirrors mtime high");
    endtask

    initial begin
        seed              = 46;
        clk               = 1'b0;
        reset_n           = 1'b0;
        read_en_i         = 1'b0;
        write_en_i        = 1'b0;
        killed_i          = 1'b0;
        op_i              = WRITE;
        addr_i            = '0;
        wdata_i           = '0;
        raise_exception_i = 1'b0;
        exception_code_i  = ILLEGAL_INSTRUCTION;
        pc_i              = '0;
        instruction_i     = '0;
        machine_return_i  = 1'b0;
        jump_i            = 1'b0;
        jump_target_i     = '0;
        mtime_i           = '0;
        irq_i             = '0;
        irq_ack_i         = 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_equal(privilege_o, MACHINE, "privilege after reset");
        check_equal(irq_pending_o, 1'b0, "pending after reset");
        test_masked_ops();
        test_killed_access();
        test_exception_return();
        test_interrupts();
        test_counters();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+design
design/csr_pkg.sv
design/csr_access.sv
design/csr_trap_regs.sv
design/csr_counters.sv
design/csr_bank.sv
test/tb_csr_bank.sv
